// File: rtl/basic_op_unit.sv
`timescale 1ns/100ps

module basic_op_unit
	import g729_pkg::*;
(
	input  op_cmd_t i_cmd,
	output op_res_t o_res
);

	function automatic logic [15:0] sat16(input logic signed [16:0] v);
		if (v > 17'sd32767)
			return 16'h7fff;
		else if (v < -17'sd32768)
			return 16'h8000;
		return v[15:0];
	endfunction

	function automatic logic [31:0] sat32(input logic signed [32:0] v);
		if (v[32] != v[31])
			return v[32] ? 32'h8000_0000 : 32'h7fff_ffff;
		return v[31:0];
	endfunction

	logic signed [15:0] a;
	logic signed [15:0] b;
	logic signed [31:0] c;
	logic signed [31:0] prod;
	logic signed [31:0] lm;
	logic signed [16:0] s17;
	logic signed [32:0] s33;
	logic signed [63:0] wide;
	logic [5:0] n;

	always_comb
	begin
		a = $signed(i_cmd.a16);
		b = $signed(i_cmd.b16);
		c = $signed(i_cmd.c32);
		prod = a * b;
		s17 = '0;
		s33 = '0;
		wide = '0;
		n = '0;
		o_res = '0;
		// L_mult only clips on -32768 * -32768
		lm = (prod == 32'sh4000_0000) ? 32'sh7fff_ffff : (prod <<< 1);
		case (i_cmd.op)
			OP_ADD, OP_SUB:
			begin
				s17 = (i_cmd.op == OP_ADD) ? (a + b) : (a - b);
				o_res.r16 = sat16(s17);
				o_res.ovf = (s17 != $signed({o_res.r16[15], o_res.r16}));
			end
			OP_MULT:
			begin
				o_res.r16 = (prod == 32'sh4000_0000) ? 16'h7fff : prod[30:15];
				o_res.ovf = (prod == 32'sh4000_0000);
			end
			OP_L_MAC, OP_L_MSU:
			begin
				if (i_cmd.op == OP_L_MAC)
					s33 = $signed({c[31], c}) + $signed({lm[31], lm});
				else
					s33 = $signed({c[31], c}) - $signed({lm[31], lm});
				o_res.r32 = sat32(s33);
				o_res.ovf = (prod == 32'sh4000_0000) || (s33[32] != s33[31]);
			end
			OP_L_SHL:
			begin
				if (b < 0)
				begin
					n = (b < -16'sd31) ? 6'd31 : 6'(-b);
					o_res.r32 = c >>> n;
				end
				else
				begin
					n = (b > 16'sd31) ? 6'd32 : 6'(b);
					wide = {{32{c[31]}}, c} <<< n;
					// Every bit above 31 must repeat the sign
					if (wide[63:31] != {33{wide[31]}})
					begin
						o_res.r32 = c[31] ? 32'h8000_0000 : 32'h7fff_ffff;
						o_res.ovf = 1'b1;
					end
					else
						o_res.r32 = wide[31:0];
				end
			end
			OP_L_SHR:
			begin
				// Negative counts act as zero here
				n = (b > 16'sd31) ? 6'd31 : ((b < 0) ? 6'd0 : 6'(b));
				o_res.r32 = c >>> n;
			end
			OP_LOAD, OP_STORE:
				o_res.r16 = i_cmd.a16;
			default: ;
		endcase
		if (i_cmd.op inside {OP_L_MAC, OP_L_MSU, OP_L_SHL, OP_L_SHR})
			o_res.r16 = o_res.r32[31:16];
		else
			o_res.r32 = {{16{o_res.r16[15]}}, o_res.r16};
	end

	always_comb
		assert final (!$isunknown(i_cmd.op));

endmodule

// File: rtl/g729_pkg.sv
package g729_pkg;

	////////////////////////////////////////
	// Memory geometry
	////////////////////////////////////////

	localparam int ADDR_W = 12;
	localparam int DATA_W = 32;

	// History words past_qua_en[0..3] sit back to back
	localparam logic [ADDR_W-1:0] PAST_QUA_EN_BASE = 12'h040;
	localparam int N_PAST = 4;

	localparam int TABLOG_SIZE = 33;

	////////////////////////////////////////
	// Algorithm constants
	////////////////////////////////////////

	localparam logic [15:0] GAIN_SCALE = 16'd24660;
	localparam logic [15:0] EXP_BIAS = 16'd13;

	////////////////////////////////////////
	// Operator commands and results
	////////////////////////////////////////

	typedef enum logic [3:0] {
		OP_NOP,
		OP_ADD,
		OP_SUB,
		OP_MULT,
		OP_L_MAC,
		OP_L_MSU,
		OP_L_SHL,
		OP_L_SHR,
		OP_LOAD,
		OP_STORE
	} op_code_t;

	// a16/b16 are the 16-bit operands, c32 the accumulator operand
	typedef struct packed {
		op_code_t op;
		logic [15:0] a16;
		logic [15:0] b16;
		logic [31:0] c32;
		logic wr_en;
		logic [ADDR_W-1:0] wr_addr;
	} op_cmd_t;

	// r16 is extract_h(r32) for the 32-bit operators
	typedef struct packed {
		logic [15:0] r16;
		logic [31:0] r32;
		logic ovf;
	} op_res_t;

endpackage

// File: rtl/gain_update_seq.sv
`timescale 1ns/100ps

module gain_update_seq
	import g729_pkg::*;
(
	input  logic i_clock,
	input  logic i_rst,
	input  logic i_start,
	input  logic [31:0] i_l_gbk12,
	input  logic [DATA_W-1:0] i_rd_data,
	input  logic [15:0] i_rom_data,
	input  op_res_t i_res,
	input  logic i_norm_done,
	input  logic [4:0] i_norm_shift,
	output op_cmd_t o_cmd,
	output logic [ADDR_W-1:0] o_rd_addr,
	output logic [ADDR_W-1:0] o_rom_addr,
	output logic o_norm_start,
	output logic [31:0] o_norm_value,
	output logic o_busy,
	output logic o_done
);

	typedef enum logic [4:0] {
		S_IDLE, S_RD2, S_ST3, S_ST2, S_ST1,
		S_LG_CHK, S_LG_NW, S_LG_SHL, S_LG_SHR9, S_LG_IDX, S_LG_FRA,
		S_LG_T0, S_LG_T1, S_LG_MSU,
		S_CP_HI, S_CP_MAC, S_CP_SHL, S_CP_MULT, S_CP_ST,
		S_FLUSH, S_DONE
	} state_t;

	state_t state, state_nx;

	// Working registers of Log2
	logic [31:0] energy;
	logic [31:0] acc;
	logic [4:0] exp_n;
	logic [5:0] idx;
	logic [15:0] a_frac;
	logic [15:0] t0;
	logic [15:0] exponent;
	logic [15:0] frac;
	op_res_t res_q;

	always_ff @(posedge i_clock)
	begin
		if (i_rst)
			state <= S_IDLE;
		else
			state <= state_nx;
	end

	always_comb
	begin
		state_nx = state;
		case (state)
			S_IDLE:   if (i_start) state_nx = S_RD2;
			S_RD2:    state_nx = S_ST3;
			S_ST3:    state_nx = S_ST2;
			S_ST2:    state_nx = S_ST1;
			S_ST1:    state_nx = S_LG_CHK;
			// Non-positive energy skips straight to L_Comp
			S_LG_CHK: state_nx = ($signed(energy) <= 0) ? S_CP_HI : S_LG_NW;
			S_LG_NW:  if (i_norm_done) state_nx = S_LG_SHL;
			S_LG_SHL: state_nx = S_LG_SHR9;
			S_LG_SHR9: state_nx = S_LG_IDX;
			S_LG_IDX: state_nx = S_LG_FRA;
			S_LG_FRA: state_nx = S_LG_T0;
			S_LG_T0:  state_nx = S_LG_T1;
			S_LG_T1:  state_nx = S_LG_MSU;
			S_LG_MSU: state_nx = S_CP_HI;
			S_CP_HI:  state_nx = S_CP_MAC;
			S_CP_MAC: state_nx = S_CP_SHL;
			S_CP_SHL: state_nx = S_CP_MULT;
			S_CP_MULT: state_nx = S_CP_ST;
			S_CP_ST:  state_nx = S_FLUSH;
			S_FLUSH:  state_nx = S_DONE;
			default:  state_nx = S_IDLE;
		endcase
	end

	////////////////////////////////////////
	// Command issue, one operator per step
	////////////////////////////////////////

	always_comb
	begin
		o_cmd = '0;
		o_cmd.op = OP_NOP;
		o_rd_addr = PAST_QUA_EN_BASE;
		o_rom_addr = ADDR_W'(idx);
		case (state)
			S_RD2:
				o_rd_addr = PAST_QUA_EN_BASE + ADDR_W'(N_PAST - 2);
			S_ST3:
			begin
				o_rd_addr = PAST_QUA_EN_BASE + ADDR_W'(N_PAST - 3);
				o_cmd.op = OP_STORE;
				o_cmd.a16 = i_rd_data[15:0];
				o_cmd.wr_en = 1'b1;
				o_cmd.wr_addr = PAST_QUA_EN_BASE + ADDR_W'(N_PAST - 1);
			end
			S_ST2:
			begin
				o_rd_addr = PAST_QUA_EN_BASE;
				o_cmd.op = OP_STORE;
				o_cmd.a16 = i_rd_data[15:0];
				o_cmd.wr_en = 1'b1;
				o_cmd.wr_addr = PAST_QUA_EN_BASE + ADDR_W'(N_PAST - 2);
			end
			S_ST1:
			begin
				o_cmd.op = OP_STORE;
				o_cmd.a16 = i_rd_data[15:0];
				o_cmd.wr_en = 1'b1;
				o_cmd.wr_addr = PAST_QUA_EN_BASE + ADDR_W'(N_PAST - 3);
			end
			S_LG_SHL:
			begin
				o_cmd.op = OP_L_SHL;
				o_cmd.c32 = energy;
				o_cmd.b16 = {11'd0, exp_n};
			end
			S_LG_SHR9:
			begin
				o_cmd.op = OP_L_SHR;
				o_cmd.c32 = acc;
				o_cmd.b16 = 16'd9;
			end
			// Table index i = extract_h(L_x >> 9) - 32
			S_LG_IDX:
			begin
				o_cmd.op = OP_SUB;
				o_cmd.a16 = res_q.r16;
				o_cmd.b16 = 16'd32;
			end
			S_LG_FRA:
			begin
				o_cmd.op = OP_L_SHR;
				o_cmd.c32 = acc;
				o_cmd.b16 = 16'd10;
			end
			S_LG_T0:
			begin
				o_rom_addr = ADDR_W'(idx) + 1'b1;
				o_cmd.op = OP_SUB;
				o_cmd.a16 = 16'd30;
				o_cmd.b16 = {11'd0, exp_n};
			end
			S_LG_T1:
			begin
				o_cmd.op = OP_SUB;
				o_cmd.a16 = t0;
				o_cmd.b16 = i_rom_data;
			end
			// Linear interpolation between the two table entries
			S_LG_MSU:
			begin
				o_cmd.op = OP_L_MSU;
				o_cmd.c32 = {t0, 16'd0};
				o_cmd.a16 = res_q.r16;
				o_cmd.b16 = a_frac;
			end
			S_CP_HI:
			begin
				o_cmd.op = OP_SUB;
				o_cmd.a16 = exponent;
				o_cmd.b16 = EXP_BIAS;
			end
			// L_Comp(hi, lo) = L_mac(hi << 16, lo, 1)
			S_CP_MAC:
			begin
				o_cmd.op = OP_L_MAC;
				o_cmd.c32 = {res_q.r16, 16'd0};
				o_cmd.a16 = frac;
				o_cmd.b16 = 16'd1;
			end
			S_CP_SHL:
			begin
				o_cmd.op = OP_L_SHL;
				o_cmd.c32 = res_q.r32;
				o_cmd.b16 = EXP_BIAS;
			end
			S_CP_MULT:
			begin
				o_cmd.op = OP_MULT;
				o_cmd.a16 = res_q.r16;
				o_cmd.b16 = GAIN_SCALE;
			end
			S_CP_ST:
			begin
				o_cmd.op = OP_STORE;
				o_cmd.a16 = res_q.r16;
				o_cmd.wr_en = 1'b1;
				o_cmd.wr_addr = PAST_QUA_EN_BASE;
			end
			default: ;
		endcase
	end

	// Operands and Log2 intermediate results
	always_ff @(posedge i_clock)
	begin
		res_q <= i_res;
		if (state == S_IDLE && i_start)
			energy <= i_l_gbk12;
		if (state == S_LG_CHK)
		begin
			exponent <= '0;
			frac <= '0;
		end
		if (state == S_LG_NW && i_norm_done)
			exp_n <= i_norm_shift;
		if (state == S_LG_SHL)
			acc <= i_res.r32;
		if (state == S_LG_IDX)
			idx <= i_res.r16[5:0];
		if (state == S_LG_FRA)
			a_frac <= {1'b0, i_res.r32[14:0]};
		if (state == S_LG_T0)
		begin
			t0 <= i_rom_data;
			exponent <= i_res.r16;
		end
		if (state == S_LG_MSU)
			frac <= i_res.r16;
	end

	assign o_norm_start = (state == S_LG_CHK) && ($signed(energy) > 0);
	assign o_norm_value = energy;
	assign o_busy = (state != S_IDLE);
	assign o_done = (state == S_DONE);

	// Log2 input must be normalized ahead of the table lookup
	assert property (@(posedge i_clock) disable iff (i_rst)
		(state == S_LG_SHR9) |-> (acc[31:30] == 2'b01));

endmodule

// File: rtl/gain_update_top.sv
`timescale 1ns/100ps

module gain_update_top
	import g729_pkg::*;
(
	input  logic i_clock,
	input  logic i_rst,
	input  logic i_start,
	input  logic [31:0] i_l_gbk12,
	input  logic i_test_mode,
	input  logic [ADDR_W-1:0] i_test_wr_addr,
	input  logic [ADDR_W-1:0] i_test_rd_addr,
	input  logic [DATA_W-1:0] i_test_wr_data,
	input  logic i_test_wr_en,
	output logic [DATA_W-1:0] o_rd_data,
	output logic o_busy,
	output logic o_done,
	output logic o_overflow
);

	op_cmd_t cmd;
	op_res_t res;
	logic start;
	logic norm_start, norm_done;
	logic [4:0] norm_shift;
	logic [31:0] norm_value;
	logic [ADDR_W-1:0] seq_rd_addr, rom_addr;
	logic [15:0] rom_data;
	logic wb_wr_en;
	logic [ADDR_W-1:0] wb_wr_addr;
	logic [DATA_W-1:0] wb_wr_data;
	logic ram_wr_en;
	logic [ADDR_W-1:0] ram_wr_addr, ram_rd_addr;
	logic [DATA_W-1:0] ram_wr_data;

	assign start = i_start & ~i_test_mode;

	////////////////////////////////////////
	// Test port muxes
	////////////////////////////////////////

	assign ram_wr_addr = i_test_mode ? i_test_wr_addr : wb_wr_addr;
	assign ram_wr_data = i_test_mode ? i_test_wr_data : wb_wr_data;
	assign ram_wr_en = i_test_mode ? i_test_wr_en : wb_wr_en;
	assign ram_rd_addr = i_test_mode ? i_test_rd_addr : seq_rd_addr;

	gain_update_seq u_seq (
		.i_clock(i_clock), .i_rst(i_rst), .i_start(start), .i_l_gbk12(i_l_gbk12),
		.i_rd_data(o_rd_data), .i_rom_data(rom_data), .i_res(res),
		.i_norm_done(norm_done), .i_norm_shift(norm_shift), .o_cmd(cmd),
		.o_rd_addr(seq_rd_addr), .o_rom_addr(rom_addr), .o_norm_start(norm_start),
		.o_norm_value(norm_value), .o_busy(o_busy), .o_done(o_done)
	);

	basic_op_unit u_ops (.i_cmd(cmd), .o_res(res));

	norm_l_unit u_norm (
		.i_clock(i_clock), .i_rst(i_rst), .i_start(norm_start), .i_value(norm_value),
		.o_shift(norm_shift), .o_done(norm_done)
	);

	op_writeback u_wb (
		.i_clock(i_clock), .i_rst(i_rst), .i_cmd(cmd), .i_res(res),
		.o_wr_en(wb_wr_en), .o_wr_addr(wb_wr_addr), .o_wr_data(wb_wr_data),
		.o_overflow(o_overflow)
	);

	scratch_ram u_ram (
		.i_clock(i_clock), .i_wr_en(ram_wr_en), .i_wr_addr(ram_wr_addr),
		.i_wr_data(ram_wr_data), .i_rd_addr(ram_rd_addr), .o_rd_data(o_rd_data)
	);

	log2_table_rom u_rom (.i_clock(i_clock), .i_addr(rom_addr), .o_data(rom_data));

endmodule

// File: rtl/log2_table_rom.sv
`timescale 1ns/100ps

module log2_table_rom
	import g729_pkg::*;
(
	input  logic i_clock,
	input  logic [ADDR_W-1:0] i_addr,
	output logic [15:0] o_data
);

	logic [15:0] tab;

	// tablog[i] = log2(1 + i/32) in Q15
	always_comb
	begin
		case (i_addr[5:0])
			6'd0:  tab = 16'd0;
			6'd1:  tab = 16'd1455;
			6'd2:  tab = 16'd2866;
			6'd3:  tab = 16'd4236;
			6'd4:  tab = 16'd5568;
			6'd5:  tab = 16'd6863;
			6'd6:  tab = 16'd8124;
			6'd7:  tab = 16'd9352;
			6'd8:  tab = 16'd10549;
			6'd9:  tab = 16'd11716;
			6'd10: tab = 16'd12855;
			6'd11: tab = 16'd13967;
			6'd12: tab = 16'd15054;
			6'd13: tab = 16'd16117;
			6'd14: tab = 16'd17156;
			6'd15: tab = 16'd18172;
			6'd16: tab = 16'd19167;
			6'd17: tab = 16'd20142;
			6'd18: tab = 16'd21097;
			6'd19: tab = 16'd22033;
			6'd20: tab = 16'd22951;
			6'd21: tab = 16'd23852;
			6'd22: tab = 16'd24735;
			6'd23: tab = 16'd25603;
			6'd24: tab = 16'd26455;
			6'd25: tab = 16'd27291;
			6'd26: tab = 16'd28113;
			6'd27: tab = 16'd28922;
			6'd28: tab = 16'd29716;
			6'd29: tab = 16'd30497;
			6'd30: tab = 16'd31266;
			6'd31: tab = 16'd32023;
			6'd32: tab = 16'd32767;
			default: tab = 16'd0;
		endcase
	end

	always_ff @(posedge i_clock)
		o_data <= (i_addr < ADDR_W'(TABLOG_SIZE)) ? tab : 16'd0;

endmodule

// File: rtl/norm_l_unit.sv
`timescale 1ns/100ps

module norm_l_unit (
	input  logic i_clock,
	input  logic i_rst,
	input  logic i_start,
	input  logic [31:0] i_value,
	output logic [4:0] o_shift,
	output logic o_done
);

	logic busy;
	logic [31:0] work;

	always_ff @(posedge i_clock)
	begin
		if (i_rst)
		begin
			busy <= 1'b0;
			o_done <= 1'b0;
			o_shift <= '0;
		end
		else
		begin
			o_done <= 1'b0;
			if (i_start)
			begin
				work <= i_value;
				o_shift <= '0;
				// Zero needs no shifting
				if (i_value == '0)
					o_done <= 1'b1;
				else
					busy <= 1'b1;
			end
			else if (busy)
			begin
				if (work[30] != work[31] || o_shift == 5'd31)
				begin
					busy <= 1'b0;
					o_done <= 1'b1;
				end
				else
				begin
					work <= work << 1;
					o_shift <= o_shift + 1'b1;
				end
			end
		end
	end

	assert property (@(posedge i_clock) disable iff (i_rst) o_done |=> !o_done);

endmodule

// File: rtl/op_writeback.sv
`timescale 1ns/100ps

module op_writeback
	import g729_pkg::*;
(
	input  logic i_clock,
	input  logic i_rst,
	input  op_cmd_t i_cmd,
	input  op_res_t i_res,
	output logic o_wr_en,
	output logic [ADDR_W-1:0] o_wr_addr,
	output logic [DATA_W-1:0] o_wr_data,
	output logic o_overflow
);

	// Control side
	always_ff @(posedge i_clock)
	begin
		if (i_rst)
		begin
			o_wr_en <= 1'b0;
			o_overflow <= 1'b0;
		end
		else
		begin
			o_wr_en <= (i_cmd.op == OP_STORE) && i_cmd.wr_en;
			// Sticky until the next reset
			o_overflow <= o_overflow | i_res.ovf;
		end
	end

	// History words are kept sign extended
	always_ff @(posedge i_clock)
	begin
		o_wr_addr <= i_cmd.wr_addr;
		o_wr_data <= {{(DATA_W-16){i_res.r16[15]}}, i_res.r16};
	end

endmodule

// File: rtl/scratch_ram.sv
`timescale 1ns/100ps

module scratch_ram
	import g729_pkg::*;
(
	input  logic i_clock,
	input  logic i_wr_en,
	input  logic [ADDR_W-1:0] i_wr_addr,
	input  logic [DATA_W-1:0] i_wr_data,
	input  logic [ADDR_W-1:0] i_rd_addr,
	output logic [DATA_W-1:0] o_rd_data
);

	logic [DATA_W-1:0] mem [0:(1 << ADDR_W)-1];

	always_ff @(posedge i_clock)
	begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

// File: sim.f
+incdir+sim
rtl/g729_pkg.sv
rtl/scratch_ram.sv
rtl/log2_table_rom.sv
rtl/norm_l_unit.sv
rtl/basic_op_unit.sv
rtl/op_writeback.sv
rtl/gain_update_seq.sv
rtl/gain_update_top.sv
sim/tb_gain_update.sv

// File: sim/gain_update_model.svh
`ifndef GAIN_UPDATE_MODEL_SVH
`define GAIN_UPDATE_MODEL_SVH

// tablog[i] = log2(1 + i/32) in Q15
localparam int TABLOG [TABLOG_SIZE] = '{
	0, 1455, 2866, 4236, 5568, 6863, 8124, 9352, 10549, 11716, 12855,
	13967, 15054, 16117, 17156, 18172, 19167, 20142, 21097, 22033, 22951,
	23852, 24735, 25603, 26455, 27291, 28113, 28922, 29716, 30497, 31266,
	32023, 32767
};

function automatic logic signed [15:0] sat16(input longint v);
	if (v > 32767)
		return 16'h7fff;
	if (v < -32768)
		return 16'h8000;
	return v[15:0];
endfunction

function automatic logic signed [31:0] sat32(input longint v);
	if (v > 64'sh7fff_ffff)
		return 32'h7fff_ffff;
	if (v < -64'sh8000_0000)
		return 32'h8000_0000;
	return v[31:0];
endfunction

function automatic logic signed [15:0] sub16(input logic signed [15:0] a,
	input logic signed [15:0] b);
	return sat16(longint'(a) - longint'(b));
endfunction

// Q15 product, floor after the shift
function automatic logic signed [15:0] mult16(input logic signed [15:0] a,
	input logic signed [15:0] b);
	return sat16((longint'(a) * longint'(b)) >>> 15);
endfunction

function automatic logic signed [31:0] l_mac(input logic signed [31:0] acc,
	input logic signed [15:0] a, input logic signed [15:0] b);
	return sat32(longint'(acc) + longint'(sat32(2 * longint'(a) * longint'(b))));
endfunction

function automatic logic signed [31:0] l_msu(input logic signed [31:0] acc,
	input logic signed [15:0] a, input logic signed [15:0] b);
	return sat32(longint'(acc) - longint'(sat32(2 * longint'(a) * longint'(b))));
endfunction

function automatic logic signed [31:0] l_shr(input logic signed [31:0] x, input int n);
	if (n >= 31)
		return x[31] ? 32'hffff_ffff : 32'h0;
	return x >>> n;
endfunction

// One bit at a time, clipping as soon as the sign would change
function automatic logic signed [31:0] l_shl(input logic signed [31:0] x, input int n);
	logic signed [31:0] v;
	int i;
	v = x;
	if (n <= 0)
		return l_shr(x, -n);
	for (i = 0; i < n; i++)
	begin
		if (v > 32'sh3fff_ffff)
			return 32'h7fff_ffff;
		if (v < -32'sh4000_0000)
			return 32'h8000_0000;
		v = v <<< 1;
	end
	return v;
endfunction

function automatic int norm_l(input logic signed [31:0] x);
	logic signed [31:0] v;
	int n;
	v = x;
	n = 0;
	if (v == 0)
		return 0;
	if (v == -1)
		return 31;
	if (v < 0)
		v = ~v;
	while (v < 32'sh4000_0000)
	begin
		v = v <<< 1;
		n++;
	end
	return n;
endfunction

// Log2 of the energy, then mult(extract_h(L_shl(L_Comp(exp - 13, frac), 13)), 24660)
function automatic logic signed [15:0] new_entry(input logic signed [31:0] energy);
	logic signed [15:0] expo;
	logic signed [15:0] frac;
	logic signed [15:0] afrac;
	logic signed [15:0] tmp;
	logic signed [31:0] lx;
	logic signed [31:0] ly;
	int n;
	int idx;
	expo = 0;
	frac = 0;
	if (energy > 0)
	begin
		n = norm_l(energy);
		lx = l_shl(energy, n);
		expo = sub16(16'sd30, 16'(n));
		lx = l_shr(lx, 9);
		idx = int'(lx[31:16]) - 32;
		lx = l_shr(lx, 1);
		afrac = {1'b0, lx[14:0]};
		ly = TABLOG[idx] <<< 16;
		tmp = sub16(16'(TABLOG[idx]), 16'(TABLOG[idx + 1]));
		ly = l_msu(ly, tmp, afrac);
		frac = ly[31:16];
	end
	tmp = sub16(expo, 16'sd13);
	ly = {tmp, 16'h0000};
	ly = l_mac(ly, frac, 16'sd1);
	lx = l_shl(ly, 13);
	tmp = lx[31:16];
	return mult16(tmp, GAIN_SCALE);
endfunction

`endif

// File: sim/tb_gain_update.sv
`timescale 1ns/100ps

module tb_gain_update
	import g729_pkg::*;
();

	`include "gain_update_model.svh"

	localparam int N_UPDATES = 24;
	localparam int N_ACCESSES = 42;
	localparam int WATCHDOG_CYCLES = 40 * N_UPDATES + 10 * N_ACCESSES + 20;

	logic clock;
	logic i_rst;
	logic i_start;
	logic [31:0] i_l_gbk12;
	logic i_test_mode;
	logic [ADDR_W-1:0] i_test_wr_addr;
	logic [ADDR_W-1:0] i_test_rd_addr;
	logic [DATA_W-1:0] i_test_wr_data;
	logic i_test_wr_en;
	logic [DATA_W-1:0] o_rd_data;
	logic o_busy;
	logic o_done;
	logic o_overflow;

	int errors = 0;
	int errors_before = 0;
	int passed = 0;
	int failed = 0;
	int seed = 32'hd8b9;

	// Expected past_qua_en, entry 0 first
	logic signed [15:0] hist [N_PAST];

	gain_update_top dut (
		.i_clock(clock), .i_rst(i_rst), .i_start(i_start), .i_l_gbk12(i_l_gbk12),
		.i_test_mode(i_test_mode), .i_test_wr_addr(i_test_wr_addr),
		.i_test_rd_addr(i_test_rd_addr), .i_test_wr_data(i_test_wr_data),
		.i_test_wr_en(i_test_wr_en), .o_rd_data(o_rd_data), .o_busy(o_busy),
		.o_done(o_done), .o_overflow(o_overflow)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
			$display("** Error: %s = %h, expected %h", name, got, exp);
		if (got !== exp)
			errors++;
	endtask

	task automatic end_test(input string name);
		if (errors == errors_before)
		begin
			$display("test %s: ok", name);
			passed++;
		end
		else
		begin
			$display("test %s: failed with %0d errors", name, errors - errors_before);
			failed++;
		end
		errors_before = errors;
	endtask

	task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		@(negedge clock);
		i_test_mode = 1'b1;
		i_test_wr_addr = addr;
		i_test_wr_data = data;
		i_test_wr_en = 1'b1;
		@(negedge clock);
		i_test_wr_en = 1'b0;
	endtask

	// Data is back one cycle after the address
	task automatic read_word(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		@(negedge clock);
		i_test_mode = 1'b1;
		i_test_rd_addr = addr;
		@(negedge clock);
		data = o_rd_data;
	endtask

	task automatic verify_history();
		logic [DATA_W-1:0] got;
		for (int i = 0; i < N_PAST; i++)
		begin
			read_word(PAST_QUA_EN_BASE + ADDR_W'(i), got);
			compare_value($sformatf("o_rd_data (past_qua_en[%0d])", i), got, 32'(hist[i]));
		end
	endtask

	// A nonzero restart_gap pulses i_start again that many cycles in
	task automatic run_update(input logic [31:0] energy, input int restart_gap);
		int cycles;
		int dones;
		int after;
		cycles = 0;
		dones = 0;
		after = 0;
		@(negedge clock);
		i_test_mode = 1'b0;
		i_l_gbk12 = energy;
		i_start = 1'b1;
		@(negedge clock);
		i_start = 1'b0;
		compare_value("o_busy", 32'(o_busy), 32'h1);
		// Keep watching a few cycles past the first done
		while (after < 4)
		begin
			if (o_done)
				dones++;
			if (dones > 0)
				after++;
			cycles++;
			@(negedge clock);
			i_start = (restart_gap != 0) && (cycles == restart_gap);
		end
		compare_value("o_done pulse count", 32'(dones), 32'h1);
		hist[3] = hist[2];
		hist[2] = hist[1];
		hist[1] = hist[0];
		hist[0] = new_entry(energy);
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic after_reset();
		@(negedge clock);
		compare_value("o_done", 32'(o_done), 32'h0);
		compare_value("o_busy", 32'(o_busy), 32'h0);
		compare_value("o_overflow", 32'(o_overflow), 32'h0);
		end_test("after_reset");
	endtask

	task automatic test_port_readback();
		logic [ADDR_W-1:0] addrs [8] = '{PAST_QUA_EN_BASE, PAST_QUA_EN_BASE + 12'd1,
			PAST_QUA_EN_BASE + 12'd2, PAST_QUA_EN_BASE + 12'd3,
			12'h000, 12'h3c5, 12'h7ff, 12'hfff};
		logic [DATA_W-1:0] got;
		for (int i = 0; i < 8; i++)
			write_word(addrs[i], {addrs[i], ~addrs[i], addrs[i][7:0]});
		for (int i = 0; i < 8; i++)
		begin
			read_word(addrs[i], got);
			compare_value($sformatf("o_rd_data @%h", addrs[i]), got,
				{addrs[i], ~addrs[i], addrs[i][7:0]});
		end
		end_test("test_port_readback");
	endtask

	task automatic single_update();
		hist = '{-16'sd1200, 16'sd2400, -16'sd3600, 16'sd4800};
		for (int i = 0; i < N_PAST; i++)
			write_word(PAST_QUA_EN_BASE + ADDR_W'(i), 32'(hist[i]));
		// Small energy keeps L_shl out of saturation
		run_update(32'h0000_3a5c, 0);
		verify_history();
		end_test("single_update");
	endtask

	task automatic saturating_updates();
		logic [DATA_W-1:0] got;
		run_update(32'h0000_0000, 0);
		verify_history();
		read_word(PAST_QUA_EN_BASE, got);
		compare_value("o_rd_data (past_qua_en[0])", got, -32'(GAIN_SCALE));
		run_update(32'h8000_1234, 0);
		verify_history();
		read_word(PAST_QUA_EN_BASE, got);
		compare_value("o_rd_data (past_qua_en[0])", got, -32'(GAIN_SCALE));
		compare_value("o_overflow", 32'(o_overflow), 32'h1);
		end_test("saturating_updates");
	endtask

	task automatic random_updates();
		for (int i = 0; i < 20; i++)
			run_update($random(seed), 0);
		verify_history();
		end_test("random_updates");
	endtask

	task automatic ignored_restart();
		run_update(32'h0001_0000, 3);
		verify_history();
		end_test("ignored_restart");
	endtask

	initial
	begin
		i_rst = 1'b1;
		i_start = 1'b0;
		i_l_gbk12 = '0;
		i_test_mode = 1'b0;
		i_test_wr_addr = '0;
		i_test_rd_addr = '0;
		i_test_wr_data = '0;
		i_test_wr_en = 1'b0;
		repeat (5) @(negedge clock);
		i_rst = 1'b0;

		after_reset();
		test_port_readback();
		single_update();
		saturating_updates();
		random_updates();
		ignored_restart();

		$display("summary: %0d tests passed, %0d failed, %0d check errors",
			passed, failed, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
